// File: common/xge_rx_consts.svh
// Receive path sizing constants shared by packages and RTL
`ifndef XGE_RX_CONSTS_SVH
`define XGE_RX_CONSTS_SVH

`define XGE_DATA_WIDTH 64      // MAC and stream word width
`define XGE_KEEP_WIDTH 8       // One mask bit per byte

`define XGE_RX_FIFO_DEPTH 64   // Data FIFO words, power of two
`define XGE_RX_INFO_DEPTH 16   // Verdict FIFO entries

// Free data FIFO words needed to admit a frame, end marker included
`define XGE_MAX_FRAME_WORDS 16

`endif

// File: common/xge_mac_pkg.sv
// MAC-side types of the receive path, the received word and the frame verdict
`include "xge_rx_consts.svh"

package xge_mac_pkg;

   // One word from the MAC, also the data FIFO entry
   typedef struct packed {
      logic [`XGE_DATA_WIDTH-1:0] data;   // Frame bytes
      logic [`XGE_KEEP_WIDTH-1:0] valid;  // Byte-valid mask, zero on end marker
   } mac_word_t;

   // Verdict FIFO entry, one per accepted frame
   typedef struct packed {
      logic bad;                          // MAC flagged the frame bad
   } frame_verdict_t;

endpackage

// File: common/axis_pkg.sv
// Stream-side types of the receive path, the output beat and frame statistics
`include "xge_rx_consts.svh"

package axis_pkg;

   // Output beat, travels beside tvalid and tready
   typedef struct packed {
      logic [`XGE_DATA_WIDTH-1:0] data;   // Frame bytes
      logic [`XGE_KEEP_WIDTH-1:0] keep;   // Byte keep mask
      logic                       last;   // Final beat of frame
      logic                       error;  // Bad frame, only with last
   } axis_beat_t;

   // Delivered frame counts, both wrap
   typedef struct packed {
      logic [15:0] good_frames;
      logic [15:0] bad_frames;
   } rx_stats_t;

endpackage

// File: logic/async_fifo.sv
// Dual-clock FIFO with Gray-coded pointers, fall-through head and write-side fill level
`timescale 1ns/1ps

module async_fifo #(
   parameter type payload_t = logic,             // Stored word type
   parameter int  DEPTH     = 16                 // Entries, power of two
) (
   input  logic                   wclk,
   input  logic                   wreset,
   input  logic                   wr_en,
   input  payload_t               wdata,
   output logic                   full,
   output logic [$clog2(DEPTH):0] fill_level,
   input  logic                   rclk,
   input  logic                   rreset,
   input  logic                   rd_en,
   output payload_t               rdata,
   output logic                   empty
);

   localparam int AW = $clog2(DEPTH);             // Address bits, pointers carry one more

   payload_t mem [DEPTH];

   logic [AW:0] wbin;
   logic [AW:0] wbin_next;
   logic [AW:0] wgray;
   logic [AW:0] rgray_s1;                         // Read pointer into write domain
   logic [AW:0] rgray_s2;
   logic [AW:0] rbin;
   logic [AW:0] rbin_next;
   logic [AW:0] rgray;
   logic [AW:0] wgray_s1;                         // Write pointer into read domain
   logic [AW:0] wgray_s2;

   function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
      logic [AW:0] b;
      b[AW] = g[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   assign wbin_next = wbin + 1'b1;
   assign rbin_next = rbin + 1'b1;

   always_ff @(posedge wclk) begin
      if (wr_en) begin
         mem[wbin[AW-1:0]] <= wdata;              // Storage only, no reset
      end
   end

   always_ff @(posedge wclk or posedge wreset) begin
      if (wreset) begin
         wbin     <= '0;
         wgray    <= '0;
         rgray_s1 <= '0;
         rgray_s2 <= '0;
      end else begin
         rgray_s1 <= rgray;
         rgray_s2 <= rgray_s1;
         if (wr_en) begin
            wbin  <= wbin_next;
            wgray <= wbin_next ^ (wbin_next >> 1);
         end
      end
   end

   // Full when pointers differ only in the two top Gray bits
   assign full       = (wgray == {~rgray_s2[AW:AW-1], rgray_s2[AW-2:0]});
   assign fill_level = wbin - gray2bin(rgray_s2); // Lags reads, never under-reports

   always_ff @(posedge rclk or posedge rreset) begin
      if (rreset) begin
         rbin     <= '0;
         rgray    <= '0;
         wgray_s1 <= '0;
         wgray_s2 <= '0;
      end else begin
         wgray_s1 <= wgray;
         wgray_s2 <= wgray_s1;
         if (rd_en) begin
            rbin  <= rbin_next;
            rgray <= rbin_next ^ (rbin_next >> 1);
         end
      end
   end

   assign empty = (rgray == wgray_s2);
   assign rdata = mem[rbin[AW-1:0]];              // Head word shows without a read

   // Writer must respect full, reader must respect empty
   assert property (@(posedge wclk) disable iff (wreset) wr_en |-> !full)
      else $error("async_fifo write while full");
   assert property (@(posedge rclk) disable iff (rreset) rd_en |-> !empty)
      else $error("async_fifo read while empty");

endmodule

// File: rx_queue/rx_queue.sv
// Receive queue that admits MAC frames and replays them as a clk-domain stream
`timescale 1ns/1ps
`include "xge_rx_consts.svh"

module rx_queue import xge_mac_pkg::*, axis_pkg::*; (
   input  logic       clk,
   input  logic       clk156,
   input  logic       reset,
   input  mac_word_t  rx_data,
   input  logic       rx_good_frame,
   input  logic       rx_bad_frame,
   output axis_beat_t beat,
   output logic       tvalid,
   input  logic       tready,
   output logic       pkt_start
);

   localparam int FILL_W = $clog2(`XGE_RX_FIFO_DEPTH) + 1;

   typedef enum logic [1:0] {ADM_IDLE, ADM_RECEIVE, ADM_DROP} adm_state_t;
   typedef enum logic {RD_IDLE, RD_HOLD} rd_state_t;

   adm_state_t        adm_state;
   adm_state_t        adm_next;
   logic              data_wr_en;
   logic              info_wr_en;
   logic              admit;                      // Frame start accepted this cycle
   logic [FILL_W-1:0] data_fill;
   logic [FILL_W-1:0] free_words;
   logic              info_full;
   frame_verdict_t    verdict_in;
   logic              start_tgl;                  // Flips once per admitted frame

   rd_state_t         rd_state;
   rd_state_t         rd_next;
   logic              data_rd_en;
   logic              info_rd_en;
   logic              data_empty;
   logic              info_empty;
   mac_word_t         data_head;
   frame_verdict_t    info_head;
   mac_word_t         hold_q;                     // Word waiting to go out as a beat
   logic              head_is_marker;
   logic              start_s1;
   logic              start_s2;
   logic              start_s3;

   async_fifo #(
      .payload_t (mac_word_t),
      .DEPTH     (`XGE_RX_FIFO_DEPTH)
   ) data_fifo (
      .wclk       (clk156),
      .wreset     (reset),
      .wr_en      (data_wr_en),
      .wdata      (rx_data),
      .full       (),                             // Admission keeps room in hand
      .fill_level (data_fill),
      .rclk       (clk),
      .rreset     (reset),
      .rd_en      (data_rd_en),
      .rdata      (data_head),
      .empty      (data_empty)
   );

   async_fifo #(
      .payload_t (frame_verdict_t),
      .DEPTH     (`XGE_RX_INFO_DEPTH)
   ) info_fifo (
      .wclk       (clk156),
      .wreset     (reset),
      .wr_en      (info_wr_en),
      .wdata      (verdict_in),
      .full       (info_full),
      .fill_level (),
      .rclk       (clk),
      .rreset     (reset),
      .rd_en      (info_rd_en),
      .rdata      (info_head),
      .empty      (info_empty)
   );

   assign free_words     = FILL_W'(`XGE_RX_FIFO_DEPTH) - data_fill;
   assign verdict_in.bad = rx_bad_frame;          // Sampled at the end marker

   // Admission on the MAC clock, whole frames or nothing
   always_comb begin
      adm_next   = adm_state;
      data_wr_en = 1'b0;
      info_wr_en = 1'b0;
      admit      = 1'b0;
      case (adm_state)
         ADM_IDLE: begin
            if (rx_data.valid == '1) begin        // Frame start word
               // Verdict slot checked too, so tiny frames cannot overrun it
               if (free_words >= FILL_W'(`XGE_MAX_FRAME_WORDS) && !info_full) begin
                  data_wr_en = 1'b1;
                  admit      = 1'b1;
                  adm_next   = ADM_RECEIVE;
               end else begin
                  adm_next = ADM_DROP;
               end
            end
         end
         ADM_RECEIVE: begin
            data_wr_en = 1'b1;                    // Data and end marker alike
            if (rx_data.valid == '0) begin
               info_wr_en = 1'b1;
               adm_next   = ADM_IDLE;
            end
         end
         ADM_DROP: begin
            if (rx_data.valid != '1) begin        // Tail of dropped frame
               adm_next = ADM_IDLE;
            end
         end
         default: adm_next = ADM_IDLE;
      endcase
   end

   always_ff @(posedge clk156 or posedge reset) begin
      if (reset) begin
         adm_state <= ADM_IDLE;
         start_tgl <= 1'b0;
      end else begin
         adm_state <= adm_next;
         if (admit) begin
            start_tgl <= ~start_tgl;
         end
      end
   end

   assign head_is_marker = !data_empty && (data_head.valid == '0);

   // Framing on the system clock, a beat leaves once the next head is known
   always_comb begin
      rd_next    = rd_state;
      data_rd_en = 1'b0;
      info_rd_en = 1'b0;
      tvalid     = 1'b0;
      case (rd_state)
         RD_IDLE: begin
            if (!data_empty) begin
               data_rd_en = 1'b1;                 // First word into hold register
               rd_next    = RD_HOLD;
            end
         end
         RD_HOLD: begin
            if (head_is_marker) begin
               tvalid = !info_empty;              // Wait for the verdict
               if (!info_empty && tready) begin
                  data_rd_en = 1'b1;              // Drop marker with verdict
                  info_rd_en = 1'b1;
                  rd_next    = RD_IDLE;
               end
            end else if (!data_empty) begin
               tvalid     = 1'b1;
               data_rd_en = tready;               // Next data word into hold
            end
         end
         default: rd_next = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (data_rd_en && !head_is_marker) begin
         hold_q <= data_head;
      end
   end

   assign beat.data  = hold_q.data;
   assign beat.keep  = hold_q.valid;
   assign beat.last  = head_is_marker;
   assign beat.error = head_is_marker && !info_empty && info_head.bad;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_state  <= RD_IDLE;
         start_s1  <= 1'b0;
         start_s2  <= 1'b0;
         start_s3  <= 1'b0;
         pkt_start <= 1'b0;
      end else begin
         rd_state  <= rd_next;
         start_s1  <= start_tgl;                  // Two-flop toggle sync
         start_s2  <= start_s1;
         start_s3  <= start_s2;
         pkt_start <= start_s2 ^ start_s3;        // One pulse per toggle
      end
   end

   // MAC never reports both verdicts at once
   assert property (@(posedge clk156) disable iff (reset) !(rx_good_frame && rx_bad_frame))
      else $error("rx_queue good and bad frame together");

   // Stalled beat holds until taken
   assert property (@(posedge clk) disable iff (reset)
      tvalid && !tready |=> tvalid && $stable(beat))
      else $error("rx_queue beat changed while stalled");

endmodule

// File: logic/rx_frame_counter.sv
// Frame counter tallying delivered good and bad frames on the stream side
`timescale 1ns/1ps

module rx_frame_counter import axis_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  axis_beat_t beat,
   input  logic       tvalid,
   input  logic       tready,
   output rx_stats_t  stats
);

   logic frame_done;                              // Last beat taken this cycle

   assign frame_done = tvalid && tready && beat.last;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stats.good_frames <= '0;
         stats.bad_frames  <= '0;
      end else if (frame_done) begin
         if (beat.error) begin
            stats.bad_frames <= stats.bad_frames + 1'b1;   // Wraps
         end else begin
            stats.good_frames <= stats.good_frames + 1'b1;
         end
      end
   end

endmodule

// File: logic/xge_rx_port.sv
// 10G Ethernet receive port joining the frame queue and the frame counters
`timescale 1ns/1ps

module xge_rx_port import xge_mac_pkg::*, axis_pkg::*; (
   input  logic       clk,
   input  logic       clk156,
   input  logic       reset,
   input  mac_word_t  rx_data,
   input  logic       rx_good_frame,
   input  logic       rx_bad_frame,
   output axis_beat_t beat,
   output logic       tvalid,
   input  logic       tready,
   output logic       pkt_start,
   output rx_stats_t  stats
);

   rx_queue rx_queue_inst (
      .clk           (clk),
      .clk156        (clk156),
      .reset         (reset),
      .rx_data       (rx_data),
      .rx_good_frame (rx_good_frame),
      .rx_bad_frame  (rx_bad_frame),
      .beat          (beat),
      .tvalid        (tvalid),
      .tready        (tready),
      .pkt_start     (pkt_start)
   );

   rx_frame_counter rx_frame_counter_inst (
      .clk    (clk),
      .reset  (reset),
      .beat   (beat),          // Counts what the stream consumer takes
      .tvalid (tvalid),
      .tready (tready),
      .stats  (stats)
   );

endmodule

// File: sim/xge_rx_port_tb.sv
// Testbench for the receive port driving a frame table on clk156 and checking beats on clk
`timescale 1ns/1ps
`include "xge_rx_consts.svh"

module xge_rx_port_tb import xge_mac_pkg::*, axis_pkg::*; ();

   localparam int CLK_PERIOD    = 100;
   localparam int CLK156_PERIOD = 64;
   localparam int SEED          = 96092;
   localparam int MODE_READY    = 0;               // tready always high
   localparam int MODE_RANDOM   = 1;               // tready toggled at random
   localparam int MODE_HOLD     = 2;               // tready held low
   localparam int NROWS         = 15;

   typedef struct {
      int         nwords;                          // Data words before the end marker
      logic [7:0] keep;                            // Mask of the final data word
      logic       bad;
      int         mode;                            // tready pattern while the row runs
   } frame_row_t;

   frame_row_t frames [NROWS] = '{
      '{1,  8'hFF, 1'b0, MODE_READY},
      '{4,  8'h0F, 1'b0, MODE_READY},
      '{12, 8'h01, 1'b0, MODE_READY},
      '{7,  8'h3F, 1'b1, MODE_READY},
      '{1,  8'hFF, 1'b1, MODE_READY},
      '{9,  8'h7F, 1'b0, MODE_RANDOM},
      '{12, 8'hFF, 1'b1, MODE_RANDOM},
      '{5,  8'h1F, 1'b0, MODE_RANDOM},
      '{12, 8'hFF, 1'b0, MODE_HOLD},               // Six 13-word frames against a stalled sink
      '{12, 8'h07, 1'b1, MODE_HOLD},
      '{12, 8'hFF, 1'b0, MODE_HOLD},
      '{12, 8'h3F, 1'b0, MODE_HOLD},
      '{12, 8'hFF, 1'b0, MODE_HOLD},               // No room left so dropped whole
      '{12, 8'hFF, 1'b1, MODE_HOLD},
      '{3,  8'h03, 1'b0, MODE_READY}               // Releases the stall
   };

   logic       clk;
   logic       clk156;
   logic       reset;
   mac_word_t  rx_data;
   logic       rx_good_frame;
   logic       rx_bad_frame;
   axis_beat_t beat;
   logic       tvalid;
   logic       tready;
   logic       pkt_start;
   rx_stats_t  stats;

   axis_beat_t exp_q[$];                           // Beats still owed by the DUT
   int         exp_rows[$];                        // Table row of each admitted frame
   logic       stalled = 1'b0;
   int         ready_mode = MODE_READY;
   int         words_written = 0;                  // Words admitted into the data FIFO
   int         words_taken = 0;                    // Beats plus end markers consumed
   int         n_admitted = 0;
   int         n_good = 0;
   int         n_bad = 0;
   int         n_starts = 0;
   int         frame_beats = 0;
   int         err_mark = 0;
   int         n_checks = 0;
   int         n_errors = 0;

   xge_rx_port xge_rx_port_inst (
      .clk           (clk),
      .clk156        (clk156),
      .reset         (reset),
      .rx_data       (rx_data),
      .rx_good_frame (rx_good_frame),
      .rx_bad_frame  (rx_bad_frame),
      .beat          (beat),
      .tvalid        (tvalid),
      .tready        (tready),
      .pkt_start     (pkt_start),
      .stats         (stats)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;
   always #(CLK156_PERIOD / 2) clk156 = ~clk156;

   task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         // Fields in order data keep last error
         $display("[FAIL] %0d ns %s: expected %h %h %b %b, got %h %h %b %b", $time, name,
                  exp.data, exp.keep, exp.last, exp.error,
                  got.data, got.keep, got.last, got.error);
      end
   endtask

   task automatic check_stats(input rx_stats_t got, input rx_stats_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("[FAIL] %0d ns stats: expected good=%0d bad=%0d, got good=%0d bad=%0d",
                  $time, exp.good_frames, exp.bad_frames, got.good_frames, got.bad_frames);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp) begin
         n_errors++;
         $display("[FAIL] %0d ns %s: expected %0d, got %0d", $time, name, exp, got);
      end
   endtask

   task automatic send_word(input mac_word_t w, input logic good, input logic bad);
      @(posedge clk156);
      rx_data       <= w;
      rx_good_frame <= good;
      rx_bad_frame  <= bad;
   endtask

   // Drives one row onto the MAC side and records its beats when admitted
   task automatic drive_frame(input int r, input bit admit);
      mac_word_t  w;
      axis_beat_t b;
      if (admit) begin
         exp_rows.push_back(r);
      end
      for (int i = 0; i < frames[r].nwords; i++) begin
         w.data  = {$urandom, $urandom};
         w.valid = (i == frames[r].nwords - 1) ? frames[r].keep : 8'hFF;
         if (admit) begin
            b.data  = w.data;
            b.keep  = w.valid;
            b.last  = (i == frames[r].nwords - 1);
            b.error = b.last && frames[r].bad;
            exp_q.push_back(b);
         end
         send_word(w, 1'b0, 1'b0);
      end
      send_word('0, !frames[r].bad, frames[r].bad); // End marker with verdict pulse
      send_word('0, 1'b0, 1'b0);                     // Idle gap
      if (admit) begin
         words_written += frames[r].nwords + 1;
         n_admitted++;
         if (frames[r].bad) n_bad++;
         else n_good++;
      end
   endtask

   task automatic wait_drained();
      while (exp_q.size() != 0) begin
         @(posedge clk156);
      end
   endtask

   always @(posedge clk) begin
      case (ready_mode)
         MODE_READY:  tready <= 1'b1;
         MODE_RANDOM: tready <= 1'($urandom_range(1, 0));
         default:     tready <= 1'b0;
      endcase
   end

   // Beat checker sampling the values from before this edge
   always @(posedge clk) begin
      if (!reset) begin
         if (pkt_start) n_starts++;
         if (stalled && !tvalid) begin
            n_errors++;
            $display("tvalid fell at %0d ns while a beat was stalled", $time);
         end
         stalled = tvalid && !tready;
         if (tvalid && exp_q.size() == 0) begin
            n_errors++;
            $display("Beat offered at %0d ns with no frame pending", $time);
         end else if (stalled) begin
            check_beat("beat while stalled", beat, exp_q[0]);
         end else if (tvalid && tready) begin
            check_beat("beat", beat, exp_q.pop_front());
         end
         if (tvalid && tready) begin
            frame_beats++;
            words_taken++;
            if (beat.last) begin
               words_taken++;                       // End marker leaves with the last beat
               $display("row %0d: %0d beats delivered, %0d mismatches",
                        exp_rows.size() ? exp_rows.pop_front() : -1, frame_beats,
                        n_errors - err_mark);
               frame_beats = 0;
               err_mark = n_errors;
            end
         end
      end
   end

   initial begin
      int total_words;
      total_words = 0;
      foreach (frames[i]) total_words += frames[i].nwords + 1;
      #(total_words * 20 * CLK_PERIOD);
      $display("Timeout: %0d beats still outstanding after %0d ns", exp_q.size(), $time);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int        prev_mode;
      int        pending;
      rx_stats_t exp_stats;
      void'($urandom(SEED));
      clk           = 1'b0;
      clk156        = 1'b0;
      reset         = 1'b1;
      rx_data       = '0;
      rx_good_frame = 1'b0;
      rx_bad_frame  = 1'b0;
      tready        = 1'b0;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      prev_mode = MODE_READY;
      foreach (frames[r]) begin
         if (frames[r].mode != MODE_HOLD) ready_mode = frames[r].mode;
         if (frames[r].mode != MODE_HOLD || prev_mode != MODE_HOLD) wait_drained();
         ready_mode = frames[r].mode;
         prev_mode  = frames[r].mode;
         pending    = words_written - words_taken;  // Words the FIFO may still hold
         if (`XGE_RX_FIFO_DEPTH - pending >= `XGE_MAX_FRAME_WORDS) begin
            drive_frame(r, 1'b1);
         end else begin
            drive_frame(r, 1'b0);
            $display("row %0d: %0d words, dropped at admission", r, frames[r].nwords);
         end
      end
      ready_mode = MODE_READY;
      wait_drained();
      repeat (20) @(posedge clk);                   // Room for stray beats and start pulses
      exp_stats.good_frames = 16'(n_good);
      exp_stats.bad_frames  = 16'(n_bad);
      check_stats(stats, exp_stats);
      check_count("pkt_start pulses", n_starts, n_admitted);
      $display("%0d checks, %0d errors, %0d of %0d frames admitted",
               n_checks, n_errors, n_admitted, NROWS);
      if (n_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: xge_rx_port.f
+incdir+common
common/xge_mac_pkg.sv
common/axis_pkg.sv
logic/async_fifo.sv
rx_queue/rx_queue.sv
logic/rx_frame_counter.sv
logic/xge_rx_port.sv
sim/xge_rx_port_tb.sv

// File: Makefile
TOP := xge_rx_port_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f xge_rx_port.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f xge_rx_port.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
